// File: build.f
+incdir+design
design/falseLockPkg.sv
design/falseLockIf.sv
design/falseLockRegs.sv
design/freqSampler.sv
design/freqAverager.sv
design/lockMonitor.sv
design/falseLockTop.sv
verification/falseLockTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= falseLockTb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed!

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv design/*.svh verification/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/falseLockTb.sv
`include "falseLock_consts.svh"

module falseLockTb;
    timeunit 1ns;
    timeprecision 1ps;
    import falseLockPkg::*;

    localparam int WaitLimit = 50;
    localparam int Latency = 3;

    logic                    clk;
    logic                    arstN;
    logic                    wrEn;
    logic [`FL_ADDR_W-1:0]   addr;
    logic [`FL_DATA_W-1:0]   wrData;
    logic [`FL_DATA_W-1:0]   rdData;
    logic                    demodSync;
    logic [`FL_DISC_W-1:0]   freq;
    logic [`FL_DISC_W-1:0]   freqError;
    logic                    carrierLock;
    logic                    highFreqOffset;
    logic [`FL_SAMPLE_W-1:0] dacData;
    logic                    dacSync;

    integer seed = 32'hde2e_964f;
    int     errCount = 0;
    int     failedTests = 0;
    int     testCount = 0;
    bit     timedOut = 1'b0;

    // expected averager state and current config
    logic [`FL_SAMPLE_W-1:0] modelFreq;
    logic [`FL_SAMPLE_W-1:0] modelAbs;
    logic [`FL_COEF_W-1:0]   alphaVal;
    logic [`FL_COEF_W-1:0]   threshVal;

    falseLockTop dut_i (
        .clk(clk), .arstN(arstN), .wrEn(wrEn), .addr(addr), .wrData(wrData),
        .rdData(rdData), .demodSync(demodSync), .freq(freq), .freqError(freqError),
        .carrierLock(carrierLock), .highFreqOffset(highFreqOffset), .dacData(dacData),
        .dacSync(dacSync)
    );

    always #10 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expVal);
        assert (got == expVal) else begin
            $display("FAILED %s: got %h, expected %h", name, got, expVal);
            errCount++;
        end
    endtask

    task automatic writeReg(input logic [`FL_ADDR_W-1:0] a, input logic [31:0] d);
        addr = a;
        wrData = d;
        wrEn = 1'b1;
        @(posedge clk);
        #2;
        wrEn = 1'b0;
    endtask

    task automatic readReg(input logic [`FL_ADDR_W-1:0] a, output logic [31:0] d);
        addr = a;
        @(posedge clk);
        #2;
        d = rdData;
    endtask

    // a*x + (1-a)*y with a = alpha/2^15, floored back to 18 bits
    function automatic logic [`FL_SAMPLE_W-1:0] avgStep(input logic [`FL_SAMPLE_W-1:0] x,
            input logic [`FL_SAMPLE_W-1:0] y, input logic [`FL_COEF_W-1:0] alpha);
        longint a;
        longint sum;
        a = longint'(alpha) * 4;
        sum = longint'($signed(x)) * a
            + longint'($signed(y)) * ((longint'(1) << `FL_FRAC_SHIFT) - a);
        return `FL_SAMPLE_W'(sum >>> `FL_FRAC_SHIFT);
    endfunction

    function automatic logic [`FL_SAMPLE_W-1:0] offsetSample(input logic [`FL_DISC_W-1:0] f);
        logic [`FL_DISC_W-1:0] n;
        n = -f;
        return {n, 6'b0};
    endfunction

    function automatic logic [`FL_SAMPLE_W-1:0] magnitude(input logic [`FL_SAMPLE_W-1:0] s);
        return s[`FL_SAMPLE_W-1] ? -s : s;
    endfunction

    function automatic logic expectOffset(input logic [`FL_SAMPLE_W-1:0] avgF,
            input logic [`FL_SAMPLE_W-1:0] avgA, input logic [`FL_COEF_W-1:0] thr,
            input logic lock);
        if (avgA > `FL_ABS_LIMIT) return 1'b1;
        if (magnitude(avgF) > {2'b00, thr}) return !lock;
        return 1'b0;
    endfunction

    // one demodSync, then wait for dacSync and check the result
    task automatic strobe(input logic [`FL_DISC_W-1:0] f, input logic [`FL_DISC_W-1:0] fe,
                          input bit offsetMode, input dacSelT sel);
        int cycles;
        logic [`FL_SAMPLE_W-1:0] s;
        logic [`FL_SAMPLE_W-1:0] m;
        logic [`FL_SAMPLE_W-1:0] expData;
        if (timedOut) return;
        s = offsetMode ? offsetSample(f) : {fe, 6'b0};
        m = offsetMode ? magnitude(s) : '0;
        modelFreq = avgStep(s, modelFreq, alphaVal);
        modelAbs = avgStep(m, modelAbs, alphaVal);
        freq = f;
        freqError = fe;
        demodSync = 1'b1;
        @(posedge clk);
        #2;
        demodSync = 1'b0;
        cycles = 0;
        while (!dacSync && cycles < WaitLimit) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!dacSync) begin
            $display("timeout: dacSync did not rise within %0d cycles", WaitLimit);
            errCount++;
            timedOut = 1'b1;
            return;
        end
        assert (cycles == Latency) else begin
            $display("dacSync rose %0d cycles after demodSync instead of %0d", cycles, Latency);
            errCount++;
        end
        case (sel)
            DAC_AVGFREQ:    expData = modelFreq;
            DAC_AVGABSFREQ: expData = modelAbs;
            default:        expData = s;
        endcase
        checkValue("dacData", 32'(dacData), 32'(expData));
        checkValue("highFreqOffset", 32'(highFreqOffset),
                   32'(expectOffset(modelFreq, modelAbs, threshVal, carrierLock)));
    endtask

    task automatic reportTest(input string name, input int startErrs);
        testCount++;
        if (errCount == startErrs) begin
            $display("test %s: ok", name);
        end else begin
            failedTests++;
            $display("test %s: %0d failed checks", name, errCount - startErrs);
        end
    endtask

    task automatic resetStateTest();
        logic [31:0] d;
        checkValue("dacSync", 32'(dacSync), 32'h0);
        checkValue("highFreqOffset", 32'(highFreqOffset), 32'h0);
        checkValue("dacData", 32'(dacData), 32'h0);
        for (int i = 0; i < 8; i++) begin
            readReg(`FL_ADDR_W'(i), d);
            checkValue($sformatf("rdData at %0d", i), d, 32'h0);
        end
    endtask

    task automatic registerTest();
        logic [`FL_ADDR_W-1:0] regAddr [4];
        logic [31:0] masks [4];
        logic [31:0] vals [4];
        logic [31:0] d;
        regAddr = '{`FL_ADDR_ALPHA, `FL_ADDR_THRESH, `FL_ADDR_MODE, `FL_ADDR_DACSEL};
        masks = '{32'hffff, 32'hffff, 32'hf, 32'hf};
        for (int i = 0; i < 4; i++) begin
            vals[i] = $random(seed);
            writeReg(regAddr[i], vals[i]);
        end
        // writes to status and unmapped space go nowhere
        writeReg(`FL_ADDR_STATUS, $random(seed));
        writeReg(3'd5, $random(seed));
        for (int i = 0; i < 4; i++) begin
            readReg(regAddr[i], d);
            checkValue($sformatf("rdData at %0d", regAddr[i]), d, vals[i] & masks[i]);
        end
        carrierLock = 1'b1;
        readReg(`FL_ADDR_STATUS, d);
        checkValue("rdData status", d, 32'h2);
        carrierLock = 1'b0;
        readReg(`FL_ADDR_STATUS, d);
        checkValue("rdData status", d, 32'h0);
        for (int a = 5; a < 8; a++) begin
            readReg(`FL_ADDR_W'(a), d);
            checkValue($sformatf("rdData at %0d", a), d, 32'h0);
        end
    endtask

    task automatic fmAveragingTest();
        alphaVal = (`FL_COEF_W'($random(seed)) & 16'h7fff) + 16'd1;
        threshVal = 16'h4000;
        writeReg(`FL_ADDR_ALPHA, 32'(alphaVal));
        writeReg(`FL_ADDR_THRESH, 32'(threshVal));
        writeReg(`FL_ADDR_MODE, 32'(MODE_FM));
        writeReg(`FL_ADDR_DACSEL, 32'(DAC_AVGFREQ));
        for (int i = 0; i < 20; i++) begin
            carrierLock = 1'($random(seed));
            strobe(`FL_DISC_W'($random(seed)), `FL_DISC_W'($random(seed)), 1'b0, DAC_AVGFREQ);
        end
        carrierLock = 1'b0;
    endtask

    task automatic offsetAveragingTest();
        alphaVal = (`FL_COEF_W'($random(seed)) & 16'h7fff) + 16'd1;
        writeReg(`FL_ADDR_ALPHA, 32'(alphaVal));
        writeReg(`FL_ADDR_MODE, 32'(MODE_OQPSK));
        writeReg(`FL_ADDR_DACSEL, 32'(DAC_AVGABSFREQ));
        for (int i = 0; i < 12; i++) begin
            strobe(`FL_DISC_W'($random(seed)), `FL_DISC_W'($random(seed)), 1'b1, DAC_AVGABSFREQ);
        end
        // instantaneous sample on the DAC, soqpsk this time
        writeReg(`FL_ADDR_MODE, 32'(MODE_SOQPSK));
        writeReg(`FL_ADDR_DACSEL, 32'(DAC_FREQ));
        for (int i = 0; i < 6; i++) begin
            strobe(`FL_DISC_W'($random(seed)), `FL_DISC_W'($random(seed)), 1'b1, DAC_FREQ);
        end
    endtask

    task automatic settleAndCheck(input logic [`FL_DISC_W-1:0] f, input logic lock,
                                  input logic expOffset);
        logic [31:0] d;
        carrierLock = lock;
        repeat (3) strobe(f, '0, 1'b1, DAC_AVGFREQ);
        checkValue("highFreqOffset", 32'(highFreqOffset), 32'(expOffset));
        readReg(`FL_ADDR_STATUS, d);
        checkValue("rdData status", d, {30'b0, lock, expOffset});
    endtask

    task automatic falseLockTest();
        // unit weight, the average follows the newest sample
        alphaVal = 16'h8000;
        threshVal = 16'h1000;
        writeReg(`FL_ADDR_ALPHA, 32'(alphaVal));
        writeReg(`FL_ADDR_THRESH, 32'(threshVal));
        writeReg(`FL_ADDR_MODE, 32'(MODE_OQPSK));
        writeReg(`FL_ADDR_DACSEL, 32'(DAC_AVGFREQ));
        settleAndCheck(12'hf00, 1'b0, 1'b1);
        settleAndCheck(12'hf00, 1'b1, 1'b0);
        // magnitude 0x18000, beyond the absolute limit
        settleAndCheck(12'ha00, 1'b1, 1'b1);
        settleAndCheck(12'ha00, 1'b0, 1'b1);
        settleAndCheck(12'h000, 1'b0, 1'b0);
        carrierLock = 1'b0;
    endtask

    initial begin
        int startErrs;
        clk = 1'b0;
        arstN = 1'b0;
        wrEn = 1'b0;
        addr = '0;
        wrData = '0;
        demodSync = 1'b0;
        freq = '0;
        freqError = '0;
        carrierLock = 1'b0;
        modelFreq = '0;
        modelAbs = '0;
        alphaVal = '0;
        threshVal = '0;
        repeat (4) @(posedge clk);
        #2;
        arstN = 1'b1;

        startErrs = errCount;
        resetStateTest();
        reportTest("reset state", startErrs);
        startErrs = errCount;
        registerTest();
        reportTest("register access", startErrs);
        startErrs = errCount;
        fmAveragingTest();
        reportTest("fm averaging", startErrs);
        startErrs = errCount;
        offsetAveragingTest();
        reportTest("oqpsk averaging", startErrs);
        startErrs = errCount;
        falseLockTest();
        reportTest("false lock", startErrs);

        $display("%0d tests, %0d failed, %0d failed checks", testCount, failedTests, errCount);
        if (errCount == 0 && !timedOut) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: design/falseLockTop.sv
`include "falseLock_consts.svh"

module falseLockTop (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    wrEn,
    input  logic [`FL_ADDR_W-1:0]   addr,
    input  logic [`FL_DATA_W-1:0]   wrData,
    output logic [`FL_DATA_W-1:0]   rdData,
    input  logic                    demodSync,
    input  logic [`FL_DISC_W-1:0]   freq,
    input  logic [`FL_DISC_W-1:0]   freqError,
    input  logic                    carrierLock,
    output logic                    highFreqOffset,
    output logic [`FL_SAMPLE_W-1:0] dacData,
    output logic                    dacSync
);
    import falseLockPkg::*;

    sampleT freqSample;
    sampleT absSample;
    logic   sampleValid;

    cfgIf cfg_i ();
    avgIf avg_i ();

    falseLockRegs regs_i (
        .clk(clk), .arstN(arstN), .wrEn(wrEn), .addr(addr), .wrData(wrData),
        .rdData(rdData), .highFreqOffset(highFreqOffset), .carrierLock(carrierLock),
        .cfg(cfg_i.regs)
    );

    freqSampler sampler_i (
        .clk(clk), .arstN(arstN), .demodSync(demodSync), .freq(freq),
        .freqError(freqError), .cfg(cfg_i.sampler), .freqSample(freqSample),
        .absSample(absSample), .sampleValid(sampleValid)
    );

    freqAverager averager_i (
        .clk(clk), .arstN(arstN), .freqSample(freqSample), .absSample(absSample),
        .sampleValid(sampleValid), .cfg(cfg_i.averager), .avg(avg_i.averager)
    );

    lockMonitor monitor_i (
        .clk(clk), .arstN(arstN), .carrierLock(carrierLock), .cfg(cfg_i.monitor),
        .avg(avg_i.monitor), .highFreqOffset(highFreqOffset), .dacData(dacData),
        .dacSync(dacSync)
    );

endmodule

// File: design/lockMonitor.sv
`include "falseLock_consts.svh"

module lockMonitor (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 carrierLock,
    cfgIf.monitor                cfg,
    avgIf.monitor                avg,
    output logic                 highFreqOffset,
    output falseLockPkg::sampleT dacData,
    output logic                 dacSync
);
    import falseLockPkg::*;

    logic [`FL_SAMPLE_W-1:0] absAvgFreq;
    logic [`FL_SAMPLE_W-1:0] threshExt;
    logic                    absOverLimit;
    logic                    avgOverThresh;
    logic                    nextOffset;
    sampleT                  nextDac;

    // magnitude of the signed average, compared unsigned
    assign absAvgFreq = avg.averageFreq[`FL_SAMPLE_W-1] ? -avg.averageFreq
                                                        : avg.averageFreq;
    assign threshExt  = `FL_SAMPLE_W'(cfg.falseLockThreshold);

    assign absOverLimit  = $unsigned(avg.averageAbsFreq) > `FL_ABS_LIMIT;
    assign avgOverThresh = absAvgFreq > threshExt;

    // big spread always flags, a moderate offset only without carrier lock
    always_comb begin
        if (absOverLimit) begin
            nextOffset = 1'b1;
        end else if (avgOverThresh) begin
            nextOffset = !carrierLock;
        end else begin
            nextOffset = 1'b0;
        end
    end

    always_comb begin
        case (cfg.dacSelect)
            DAC_AVGFREQ:    nextDac = avg.averageFreq;
            DAC_AVGABSFREQ: nextDac = avg.averageAbsFreq;
            // error sample in the non-offset modes, own code in the map
            DAC_FREQERROR:  nextDac = avg.instFreq;
            default:        nextDac = avg.instFreq;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            highFreqOffset <= 1'b0;
            dacData        <= '0;
            dacSync        <= 1'b0;
        end else begin
            dacSync <= avg.avgValid;
            if (avg.avgValid) begin
                highFreqOffset <= nextOffset;
                dacData        <= nextDac;
            end
        end
    end

endmodule

// File: design/freqAverager.sv
`include "falseLock_consts.svh"

module freqAverager (
    input  logic                 clk,
    input  logic                 arstN,
    input  falseLockPkg::sampleT freqSample,
    input  falseLockPkg::sampleT absSample,
    input  logic                 sampleValid,
    cfgIf.averager               cfg,
    avgIf.averager               avg
);
    import falseLockPkg::*;

    // alpha as Q17, one guard bit so the complement can go negative
    logic signed [`FL_SAMPLE_W:0] alphaQ;
    logic signed [`FL_SAMPLE_W:0] alphaComp;
    sampleT freqState;
    sampleT absState;
    sampleT lastSample;
    logic   updated;

    assign alphaQ    = $signed({1'b0, cfg.falseLockAlpha, 2'b00});
    assign alphaComp = $signed(19'h20000) - alphaQ;

    // a*x + (1-a)*y, back to sample scale
    function automatic sampleT blend(input sampleT x, input sampleT y,
                                     input logic signed [`FL_SAMPLE_W:0] a,
                                     input logic signed [`FL_SAMPLE_W:0] b);
        logic signed [`FL_SAMPLE_W+19:0] sum;
        sum = x * a + y * b;
        return sum[`FL_FRAC_SHIFT +: `FL_SAMPLE_W];
    endfunction

    // smoothed state, one update per sample
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            freqState  <= '0;
            absState   <= '0;
            lastSample <= '0;
            updated    <= 1'b0;
        end else begin
            updated <= sampleValid;
            if (sampleValid) begin
                freqState  <= blend(freqSample, freqState, alphaQ, alphaComp);
                absState   <= blend(absSample, absState, alphaQ, alphaComp);
                lastSample <= freqSample;
            end
        end
    end

    // hold the result for the monitor while the state moves on
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            avg.averageFreq    <= '0;
            avg.averageAbsFreq <= '0;
            avg.instFreq       <= '0;
            avg.avgValid       <= 1'b0;
        end else begin
            avg.avgValid <= updated;
            if (updated) begin
                avg.averageFreq    <= freqState;
                avg.averageAbsFreq <= absState;
                avg.instFreq       <= lastSample;
            end
        end
    end

endmodule

// File: design/freqSampler.sv
`include "falseLock_consts.svh"

module freqSampler (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 demodSync,
    input  falseLockPkg::discT   freq,
    input  falseLockPkg::discT   freqError,
    cfgIf.sampler                cfg,
    output falseLockPkg::sampleT freqSample,
    output falseLockPkg::sampleT absSample,
    output logic                 sampleValid
);
    import falseLockPkg::*;

    localparam int PadW = `FL_SAMPLE_W - `FL_DISC_W;

    discT   negFreq;
    sampleT offsetSample;
    sampleT nextSample;
    sampleT nextAbs;

    // offset modes track the inverted discriminator
    assign negFreq      = -freq;
    assign offsetSample = {negFreq, {PadW{1'b0}}};

    always_comb begin
        case (cfg.demodMode)
            MODE_OQPSK, MODE_SOQPSK: begin
                nextSample = offsetSample;
                nextAbs    = offsetSample[`FL_SAMPLE_W-1] ? -offsetSample : offsetSample;
            end
            default: begin
                nextSample = {freqError, {PadW{1'b0}}};
                nextAbs    = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            freqSample  <= '0;
            absSample   <= '0;
            sampleValid <= 1'b0;
        end else begin
            sampleValid <= demodSync;
            if (demodSync) begin
                freqSample <= nextSample;
                absSample  <= nextAbs;
            end
        end
    end

endmodule

// File: design/falseLockRegs.sv
`include "falseLock_consts.svh"

module falseLockRegs (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  wrEn,
    input  logic [`FL_ADDR_W-1:0] addr,
    input  logic [`FL_DATA_W-1:0] wrData,
    output logic [`FL_DATA_W-1:0] rdData,
    input  logic                  highFreqOffset,
    input  logic                  carrierLock,
    cfgIf.regs                    cfg
);
    import falseLockPkg::*;

    // configuration registers, low bits of the write data
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cfg.falseLockAlpha     <= '0;
            cfg.falseLockThreshold <= '0;
            cfg.demodMode          <= MODE_FM;
            cfg.dacSelect          <= DAC_FREQ;
        end else if (wrEn) begin
            case (addr)
                `FL_ADDR_ALPHA: begin
                    cfg.falseLockAlpha <= coefT'(wrData[`FL_COEF_W-1:0]);
                end
                `FL_ADDR_THRESH: begin
                    cfg.falseLockThreshold <= coefT'(wrData[`FL_COEF_W-1:0]);
                end
                `FL_ADDR_MODE: begin
                    cfg.demodMode <= demodModeT'(wrData[$bits(demodModeT)-1:0]);
                end
                `FL_ADDR_DACSEL: begin
                    cfg.dacSelect <= dacSelT'(wrData[$bits(dacSelT)-1:0]);
                end
                default: begin
                end
            endcase
        end
    end

    // readback straight from the address
    always_comb begin
        case (addr)
            `FL_ADDR_ALPHA:  rdData = `FL_DATA_W'(cfg.falseLockAlpha);
            `FL_ADDR_THRESH: rdData = `FL_DATA_W'(cfg.falseLockThreshold);
            `FL_ADDR_MODE:   rdData = `FL_DATA_W'(cfg.demodMode);
            `FL_ADDR_DACSEL: rdData = `FL_DATA_W'(cfg.dacSelect);
            // bit 0 false lock, bit 1 carrier lock
            `FL_ADDR_STATUS: rdData = `FL_DATA_W'({carrierLock, highFreqOffset});
            default:         rdData = '0;
        endcase
    end

endmodule

// File: design/falseLockIf.sv
`include "falseLock_consts.svh"

// configuration from the register file
interface cfgIf;
    import falseLockPkg::*;

    coefT      falseLockAlpha;
    coefT      falseLockThreshold;
    demodModeT demodMode;
    dacSelT    dacSelect;

    modport regs (output falseLockAlpha, falseLockThreshold, demodMode, dacSelect);
    modport sampler (input demodMode);
    modport averager (input falseLockAlpha);
    modport monitor (input falseLockThreshold, dacSelect);
endinterface

// averager results toward the lock monitor
interface avgIf;
    import falseLockPkg::*;

    sampleT averageFreq;
    sampleT averageAbsFreq;
    // sample that went into this update
    sampleT instFreq;
    logic   avgValid;

    modport averager (output averageFreq, averageAbsFreq, instFreq, avgValid);
    modport monitor (input averageFreq, averageAbsFreq, instFreq, avgValid);
endinterface

// File: design/falseLockPkg.sv
`include "falseLock_consts.svh"

package falseLockPkg;

    // discriminator and frequency-error words from the FM detector
    typedef logic [`FL_DISC_W-1:0] discT;

    // frequency samples and averages, two's complement
    typedef logic signed [`FL_SAMPLE_W-1:0] sampleT;

    // processor coefficients
    typedef logic [`FL_COEF_W-1:0] coefT;

    typedef enum logic [3:0] {
        MODE_FM     = 4'd0,
        MODE_BPSK   = 4'd1,
        MODE_QPSK   = 4'd2,
        MODE_OQPSK  = 4'd3,
        MODE_SOQPSK = 4'd4
    } demodModeT;

    typedef enum logic [3:0] {
        DAC_FREQ       = 4'd0,
        DAC_FREQERROR  = 4'd1,
        DAC_AVGFREQ    = 4'd2,
        DAC_AVGABSFREQ = 4'd3
    } dacSelT;

endpackage

// File: design/falseLock_consts.svh
`ifndef FALSELOCK_CONSTS_SVH
`define FALSELOCK_CONSTS_SVH

// datapath widths
`define FL_DISC_W       12
`define FL_SAMPLE_W     18
`define FL_COEF_W       16

// processor bus
`define FL_ADDR_W       3
`define FL_DATA_W       32

// register map
`define FL_ADDR_ALPHA   3'd0
`define FL_ADDR_THRESH  3'd1
`define FL_ADDR_MODE    3'd2
`define FL_ADDR_DACSEL  3'd3
`define FL_ADDR_STATUS  3'd4

// decision limit and coefficient scaling
`define FL_ABS_LIMIT    18'h10000
`define FL_FRAC_SHIFT   17

`endif
